/* bench/ptr_alloc_tb.sv */
module ptr_alloc_tb import alloc_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // Operations in the stimulus table
    typedef enum {ALLOC, DEALLOC, IDLE_DISABLED} op_t;

    // One table row, expectations taken from the free-list model
    typedef struct {
        op_t op;
        int  ptr;       // pointer, -1 for a full pool, cycle count when idle
        bit  exp_err;
        int  exp_use;
        int  exp_errs;
        int  test;
    } entry_t;

    logic                   clk;
    logic                   reset;
    logic                   en;
    logic                   init_done;
    logic                   alloc_req;
    logic                   alloc_rdy;
    ptr_t                   alloc_ptr;
    logic                   dealloc_req;
    ptr_t                   dealloc_ptr;
    logic                   dealloc_rdy;
    logic                   dealloc_err;
    ptr_t                   err_ptr;
    logic [PTR_WID:0]       in_use;
    logic [ERR_CNT_WID-1:0] err_cnt;

    entry_t                 table_q [$];
    bit                     table_ready;
    // Free-list model, set bit means in use
    logic [NUM_PTRS-1:0]    used_m;
    int                     errs_m;
    int unsigned            lcg_state = 77508;

    // Run bookkeeping
    int cur_test;
    int test_errs;
    int total_errs;
    int tests_run;
    int tests_bad;

    ptr_alloc_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==================================================================
    // Model and table construction
    // ==================================================================

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    // Lowest clear bit of the model, -1 when full
    function automatic int lowest_free();
        int idx;
        idx = -1;
        for (int i = NUM_PTRS - 1; i >= 0; i--) begin
            if (!used_m[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic void push_entry(op_t op, int ptr, bit err, int test);
        entry_t e;
        e.op       = op;
        e.ptr      = ptr;
        e.exp_err  = err;
        e.exp_use  = $countones(used_m);
        e.exp_errs = errs_m;
        e.test     = test;
        table_q.push_back(e);
    endfunction

    function automatic int add_alloc(int test);
        int p;
        p = lowest_free();
        if (p >= 0) begin
            used_m[p] = 1'b1;
        end
        push_entry(ALLOC, p, 1'b0, test);
        return p;
    endfunction

    function automatic void add_free(int test, int p);
        bit err;
        // Freeing a clear bit is a double free
        err = !used_m[p];
        if (err) begin
            errs_m++;
        end
        used_m[p] = 1'b0;
        push_entry(DEALLOC, p, err, test);
    endfunction

    function automatic void build_table();
        int order [16];
        int j;
        int tmp;
        used_m = '0;
        errs_m = 0;
        // Single alloc and free
        void'(add_alloc(2));
        add_free(2, 0);
        // Fill the pool, one extra alloc on a full pool, drain
        for (int i = 0; i < NUM_PTRS; i++) begin
            void'(add_alloc(3));
        end
        void'(add_alloc(3));
        for (int i = 0; i < NUM_PTRS; i++) begin
            add_free(3, i);
        end
        // Shuffled frees then repeats of a few
        for (int i = 0; i < 16; i++) begin
            order[i] = add_alloc(4);
        end
        for (int i = 15; i > 0; i--) begin
            j        = next_rand() % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 16; i++) begin
            add_free(4, order[i]);
        end
        for (int i = 0; i < 6; i++) begin
            add_free(4, order[next_rand() % 16]);
        end
        // Holes in the middle of the pool
        for (int i = 0; i < 24; i++) begin
            void'(add_alloc(5));
        end
        add_free(5, 5);
        add_free(5, 17);
        add_free(5, 12);
        for (int i = 0; i < 4; i++) begin
            void'(add_alloc(5));
        end
        // Disabled window then resume
        push_entry(IDLE_DISABLED, 15, 1'b0, 6);
        void'(add_alloc(6));
        void'(add_alloc(6));
    endfunction

    // ==================================================================
    // Reporting
    // ==================================================================

    task automatic report_mismatch(string name, int exp, int got);
        $display("ERROR at %0d ns: %s expected %0d, got %0d", $time, name, exp, got);
        test_errs++;
        total_errs++;
    endtask

    task automatic report_failure(string what);
        $display("Failure at %0d ns in test %0d: %s", $time, cur_test, what);
        test_errs++;
        total_errs++;
    endtask

    function automatic string test_title(int t);
        case (t)
            1:       return "init sweep";
            2:       return "single alloc and free";
            3:       return "fill and drain";
            4:       return "shuffled and double frees";
            5:       return "lowest free after holes";
            default: return "enable gating";
        endcase
    endfunction

    task automatic finish_test();
        $display("test %0d %s finished with %0d errors", cur_test, test_title(cur_test),
                 test_errs);
        tests_run++;
        if (test_errs != 0) begin
            tests_bad++;
        end
        test_errs = 0;
    endtask

    // ==================================================================
    // Operations, all driven on falling edges
    // ==================================================================

    task automatic run_alloc(entry_t e);
        int waited;
        waited    = 0;
        alloc_req = 1'b1;
        if (e.ptr < 0) begin
            // Full pool, nothing may be offered
            repeat (20) begin
                @(negedge clk);
                if (alloc_rdy !== 1'b0) report_mismatch("alloc_rdy", 0, alloc_rdy);
            end
            if (int'(in_use) != e.exp_use) report_mismatch("in_use", e.exp_use, in_use);
        end else begin
            while (alloc_rdy !== 1'b1 && waited < 100) begin
                @(negedge clk);
                waited++;
            end
            if (alloc_rdy !== 1'b1) begin
                report_failure("alloc_rdy did not rise within 100 cycles");
            end else begin
                if (int'(alloc_ptr) != e.ptr) report_mismatch("alloc_ptr", e.ptr, alloc_ptr);
                // Transfer on the coming rising edge
                @(negedge clk);
                if (alloc_rdy !== 1'b0) report_mismatch("alloc_rdy", 0, alloc_rdy);
                if (int'(in_use) != e.exp_use) report_mismatch("in_use", e.exp_use, in_use);
            end
        end
        alloc_req = 1'b0;
    endtask

    task automatic run_dealloc(entry_t e);
        int waited;
        waited      = 0;
        dealloc_ptr = ptr_t'(e.ptr);
        dealloc_req = 1'b1;
        while (dealloc_rdy !== 1'b1 && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (dealloc_rdy !== 1'b1) begin
            report_failure("dealloc_rdy did not rise within 100 cycles");
            dealloc_req = 1'b0;
        end else begin
            // Accepted on the rising edge just passed
            @(negedge clk);
            dealloc_req = 1'b0;
            // READ then WRITE, port closed
            repeat (2) begin
                if (dealloc_rdy !== 1'b0) report_mismatch("dealloc_rdy", 0, dealloc_rdy);
                if (dealloc_err !== 1'b0) report_mismatch("dealloc_err", 0, dealloc_err);
                @(negedge clk);
            end
            if (dealloc_rdy !== 1'b1) report_mismatch("dealloc_rdy", 1, dealloc_rdy);
            if (dealloc_err !== e.exp_err) report_mismatch("dealloc_err", e.exp_err, dealloc_err);
            if (e.exp_err && int'(err_ptr) != e.ptr) report_mismatch("err_ptr", e.ptr, err_ptr);
            if (int'(in_use) != e.exp_use) report_mismatch("in_use", e.exp_use, in_use);
            if (int'(err_cnt) != e.exp_errs) report_mismatch("err_cnt", e.exp_errs, err_cnt);
            // Error flag is a single cycle pulse
            @(negedge clk);
            if (dealloc_err !== 1'b0) report_mismatch("dealloc_err", 0, dealloc_err);
        end
    endtask

    task automatic run_disabled_gap(entry_t e);
        en = 1'b0;
        // Let en_q fall before asking, a held pointer would transfer
        @(negedge clk);
        alloc_req = 1'b1;
        repeat (e.ptr) begin
            @(negedge clk);
            if (alloc_rdy !== 1'b0) report_mismatch("alloc_rdy", 0, alloc_rdy);
            if (int'(in_use) != e.exp_use) report_mismatch("in_use", e.exp_use, in_use);
        end
        alloc_req = 1'b0;
        en        = 1'b1;
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================

    initial begin
        entry_t e;
        int     cycles;
        reset       = 1'b1;
        en          = 1'b1;
        alloc_req   = 1'b0;
        dealloc_req = 1'b0;
        dealloc_ptr = '0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Init sweep length and closed ports meanwhile
        cur_test = 1;
        cycles   = 0;
        if (dealloc_err !== 1'b0) report_mismatch("dealloc_err", 0, dealloc_err);
        while (init_done !== 1'b1 && cycles < 4 * NUM_WORDS) begin
            if (alloc_rdy !== 1'b0) report_mismatch("alloc_rdy", 0, alloc_rdy);
            if (dealloc_rdy !== 1'b0) report_mismatch("dealloc_rdy", 0, dealloc_rdy);
            @(negedge clk);
            cycles++;
        end
        if (cycles != NUM_WORDS) report_mismatch("init_done cycles", NUM_WORDS, cycles);
        finish_test();

        cur_test = 2;
        foreach (table_q[i]) begin
            e = table_q[i];
            if (e.test != cur_test) begin
                finish_test();
                cur_test = e.test;
            end
            case (e.op)
                ALLOC:   run_alloc(e);
                DEALLOC: run_dealloc(e);
                default: run_disabled_gap(e);
            endcase
            // Random idle gap
            repeat (next_rand() % 4) @(negedge clk);
        end
        finish_test();

        $display("%0d tests run, %0d with errors, %0d errors in total",
                 tests_run, tests_bad, total_errs);
        if (total_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table plus reset and init
    initial begin
        int limit;
        wait (table_ready);
        limit = table_q.size() * 200 + 2 + NUM_WORDS + 20;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not complete", limit);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* hdl/alloc_bitmap.sv */
module alloc_bitmap import alloc_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    output logic           init_done,
    bitmap_if.bitmap_scan  scan,
    bitmap_if.bitmap_rel   rel,
    output logic           stall
);

    // One bit per pointer, set means in use
    word_t  bitmap [NUM_WORDS];

    waddr_t init_waddr;

    // Alloc bit as a word mask
    word_t  set_mask;
    // Alloc set lands on the word the release side touches
    logic   set_hits_wr;
    logic   set_hits_rd;

    // ==================================================================
    // Arbitration
    // ==================================================================

    // Release side owns the port when both ask
    assign stall = scan.scan_rd_en && (rel.rel_rd_en || rel.rel_wr_en);

    assign set_mask = word_t'(1) << scan.alloc_bit;

    assign set_hits_wr = scan.alloc_set && rel.rel_wr_en &&
                         (scan.alloc_waddr == rel.rel_wr_addr);
    assign set_hits_rd = scan.alloc_set && rel.rel_rd_en &&
                         (scan.alloc_waddr == rel.rel_rd_addr);

    // ==================================================================
    // Init sweep
    // ==================================================================

    // One word cleared per clock after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            init_waddr <= '0;
            init_done  <= 1'b0;
        end else if (!init_done) begin
            init_waddr <= init_waddr + 1'b1;
            // Last word goes clear on this edge
            if (init_waddr == waddr_t'(NUM_WORDS - 1)) begin
                init_done <= 1'b1;
            end
        end
    end

    // ==================================================================
    // Storage
    // ==================================================================

    always_ff @(posedge clk) begin
        if (!init_done) begin
            bitmap[init_waddr] <= '0;
        end else begin
            // Release write carries the cleared bit
            // Merge a same-word alloc so it is not lost
            if (rel.rel_wr_en) begin
                bitmap[rel.rel_wr_addr] <= rel.rel_wr_data |
                                           (set_hits_wr ? set_mask : '0);
            end
            // Alloc set on its own
            if (scan.alloc_set && !set_hits_wr) begin
                bitmap[scan.alloc_waddr] <= bitmap[scan.alloc_waddr] | set_mask;
            end
        end
    end

    // Read data one cycle after the enable
    always_ff @(posedge clk) begin
        // Scan read dropped on a stall, scan side retries
        if (scan.scan_rd_en && !stall) begin
            scan.scan_rd_data <= bitmap[scan.scan_rd_addr];
        end
        // Forward an alloc on the same edge so the RMW sees it
        if (rel.rel_rd_en) begin
            rel.rel_rd_data <= bitmap[rel.rel_rd_addr] |
                               (set_hits_rd ? set_mask : '0);
        end
    end

endmodule

/* hdl/alloc_ctrl.sv */
module alloc_ctrl import alloc_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   en,
    output logic                   en_q,
    input  logic                   alloc_fire,
    input  logic                   rel_fire,
    input  logic                   rel_err,
    input  ptr_t                   rel_ptr,
    output logic                   dealloc_err,
    output ptr_t                   err_ptr,
    output logic [PTR_WID:0]       in_use,
    output logic [ERR_CNT_WID-1:0] err_cnt
);

    // Successful free
    logic rel_ok;

    assign rel_ok = rel_fire && !rel_err;

    // Enable towards the scan side
    always_ff @(posedge clk) begin
        if (reset) begin
            en_q <= 1'b0;
        end else begin
            en_q <= en;
        end
    end

    // ==================================================================
    // Statistics
    // ==================================================================

    // In-use count moves on the same edge as the bitmap
    always_ff @(posedge clk) begin
        if (reset) begin
            in_use <= '0;
        end else if (alloc_fire && !rel_ok) begin
            in_use <= in_use + 1'b1;
        end else if (rel_ok && !alloc_fire) begin
            in_use <= in_use - 1'b1;
        end
    end

    // Error pulse, counter and last bad pointer
    always_ff @(posedge clk) begin
        if (reset) begin
            dealloc_err <= 1'b0;
            err_ptr     <= '0;
            err_cnt     <= '0;
        end else begin
            dealloc_err <= rel_err;
            if (rel_err) begin
                err_ptr <= rel_ptr;
                // Saturates at all ones
                if (err_cnt != '1) begin
                    err_cnt <= err_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/alloc_pkg.sv */
package alloc_pkg;

    // ==================================================================
    // Pool geometry
    // ==================================================================

    // Pointer width and pool size
    localparam int PTR_WID     = 6;
    localparam int NUM_PTRS    = 2 ** PTR_WID;

    // Bitmap organisation, one bit per pointer
    localparam int WORD_WID    = 8;
    localparam int NUM_WORDS   = NUM_PTRS / WORD_WID;
    localparam int WADDR_WID   = $clog2(NUM_WORDS);
    localparam int BIDX_WID    = $clog2(WORD_WID);

    // Statistics
    localparam int ERR_CNT_WID = 8;

    // ==================================================================
    // Types
    // ==================================================================

    typedef logic [PTR_WID-1:0]   ptr_t;
    typedef logic [WORD_WID-1:0]  word_t;
    typedef logic [WADDR_WID-1:0] waddr_t;
    // Bit position inside one word
    typedef logic [BIDX_WID-1:0]  bidx_t;

    // Free pointer search
    typedef enum logic [1:0] {
        SCAN,
        FOUND,
        WAIT
    } scan_state_t;

    // Release read-modify-write
    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE
    } rel_state_t;

endpackage

/* hdl/bitmap_if.sv */
interface bitmap_if import alloc_pkg::*; ();

    // Scan side read port
    logic   scan_rd_en;
    waddr_t scan_rd_addr;
    word_t  scan_rd_data;

    // Bit set on an alloc transfer
    logic   alloc_set;
    waddr_t alloc_waddr;
    bidx_t  alloc_bit;

    // Release side read and write ports
    logic   rel_rd_en;
    waddr_t rel_rd_addr;
    word_t  rel_rd_data;
    logic   rel_wr_en;
    waddr_t rel_wr_addr;
    word_t  rel_wr_data;

    modport scan (
        output scan_rd_en, scan_rd_addr, alloc_set, alloc_waddr, alloc_bit,
        input  scan_rd_data
    );

    modport rel (
        output rel_rd_en, rel_rd_addr, rel_wr_en, rel_wr_addr, rel_wr_data,
        input  rel_rd_data
    );

    modport bitmap_scan (
        input  scan_rd_en, scan_rd_addr, alloc_set, alloc_waddr, alloc_bit,
        output scan_rd_data
    );

    modport bitmap_rel (
        input  rel_rd_en, rel_rd_addr, rel_wr_en, rel_wr_addr, rel_wr_data,
        output rel_rd_data
    );

endinterface

/* hdl/free_scan.sv */
module free_scan import alloc_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   init_done,
    input  logic   en_q,
    input  logic   rel_done,
    input  logic   stall,
    bitmap_if.scan bm,
    input  logic   alloc_req,
    output logic   alloc_rdy,
    output ptr_t   alloc_ptr,
    output logic   alloc_fire
);

    scan_state_t state;

    // Word under examination
    waddr_t      waddr;
    // Read issued, data valid this cycle
    logic        rd_pend;

    // Prefetched pointer
    ptr_t        ptr_q;

    logic        word_full;
    bidx_t       free_bit;

    // Priority encoder, lowest clear bit of a word
    function automatic bidx_t lowest_zero(input word_t w);
        bidx_t idx;
        idx = '0;
        // Walk downward so the lowest hit wins
        for (int i = WORD_WID - 1; i >= 0; i--) begin
            if (!w[i]) begin
                idx = bidx_t'(i);
            end
        end
        return idx;
    endfunction

    assign word_full = &bm.scan_rd_data;
    assign free_bit  = lowest_zero(bm.scan_rd_data);

    // ==================================================================
    // Bitmap access
    // ==================================================================

    // One read in flight at a time
    assign bm.scan_rd_en   = (state == SCAN) && !rd_pend && init_done && en_q;
    assign bm.scan_rd_addr = waddr;

    // Transfer marks the held bit as used
    assign bm.alloc_set   = alloc_fire;
    assign bm.alloc_waddr = ptr_q[PTR_WID-1:BIDX_WID];
    assign bm.alloc_bit   = ptr_q[BIDX_WID-1:0];

    // ==================================================================
    // Alloc handshake
    // ==================================================================

    assign alloc_rdy  = (state == FOUND) && en_q;
    assign alloc_fire = alloc_rdy && alloc_req;
    assign alloc_ptr  = ptr_q;

    // ==================================================================
    // Search FSM
    // ==================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= SCAN;
            waddr   <= '0;
            rd_pend <= 1'b0;
        end else if (rel_done) begin
            // A freed pointer may sit below the held one
            // Restart from word 0
            state   <= SCAN;
            waddr   <= '0;
            rd_pend <= 1'b0;
        end else if (!en_q) begin
            // Disabled, hold nothing
            // Lower words only change via release so waddr stays
            state   <= SCAN;
            rd_pend <= 1'b0;
        end else begin
            case (state)
                SCAN: begin
                    if (rd_pend) begin
                        rd_pend <= 1'b0;
                        if (!word_full) begin
                            state <= FOUND;
                        end else if (waddr == waddr_t'(NUM_WORDS - 1)) begin
                            // Full pass, nothing free
                            state <= WAIT;
                        end else begin
                            waddr <= waddr + 1'b1;
                        end
                    end else if (bm.scan_rd_en && !stall) begin
                        rd_pend <= 1'b1;
                    end
                end
                FOUND: begin
                    // Words below stay full, resume at the current one
                    if (alloc_fire) begin
                        state <= SCAN;
                    end
                end
                WAIT: begin
                    // Pool full, only a release gets us out
                    state <= WAIT;
                end
                default: begin
                    state <= SCAN;
                end
            endcase
        end
    end

    // Capture the pointer when the word shows a hole
    always_ff @(posedge clk) begin
        if ((state == SCAN) && rd_pend && !word_full) begin
            ptr_q <= {waddr, free_bit};
        end
    end

endmodule

/* hdl/ptr_alloc_top.sv */
module ptr_alloc_top import alloc_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   en,
    output logic                   init_done,
    // Alloc port
    input  logic                   alloc_req,
    output logic                   alloc_rdy,
    output ptr_t                   alloc_ptr,
    // Dealloc port
    input  logic                   dealloc_req,
    input  ptr_t                   dealloc_ptr,
    output logic                   dealloc_rdy,
    // Status
    output logic                   dealloc_err,
    output ptr_t                   err_ptr,
    output logic [PTR_WID:0]       in_use,
    output logic [ERR_CNT_WID-1:0] err_cnt
);

    logic en_q;
    logic stall;
    logic alloc_fire;
    logic rel_done;
    logic rel_fire;
    logic rel_err;
    ptr_t rel_ptr;

    // Bitmap access bus
    bitmap_if bm_if ();

    // ==================================================================
    // Datapath
    // ==================================================================

    alloc_bitmap u_bitmap (
        .clk       (clk),
        .reset     (reset),
        .init_done (init_done),
        .scan      (bm_if.bitmap_scan),
        .rel       (bm_if.bitmap_rel),
        .stall     (stall)
    );

    free_scan u_scan (
        .clk        (clk),
        .reset      (reset),
        .init_done  (init_done),
        .en_q       (en_q),
        .rel_done   (rel_done),
        .stall      (stall),
        .bm         (bm_if.scan),
        .alloc_req  (alloc_req),
        .alloc_rdy  (alloc_rdy),
        .alloc_ptr  (alloc_ptr),
        .alloc_fire (alloc_fire)
    );

    ptr_release u_release (
        .clk         (clk),
        .reset       (reset),
        .init_done   (init_done),
        .dealloc_req (dealloc_req),
        .dealloc_ptr (dealloc_ptr),
        .dealloc_rdy (dealloc_rdy),
        .bm          (bm_if.rel),
        .rel_done    (rel_done),
        .rel_fire    (rel_fire),
        .rel_err     (rel_err),
        .rel_ptr     (rel_ptr)
    );

    // ==================================================================
    // Control and statistics
    // ==================================================================

    alloc_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .en          (en),
        .en_q        (en_q),
        .alloc_fire  (alloc_fire),
        .rel_fire    (rel_fire),
        .rel_err     (rel_err),
        .rel_ptr     (rel_ptr),
        .dealloc_err (dealloc_err),
        .err_ptr     (err_ptr),
        .in_use      (in_use),
        .err_cnt     (err_cnt)
    );

endmodule

/* hdl/ptr_release.sv */
module ptr_release import alloc_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  init_done,
    input  logic  dealloc_req,
    input  ptr_t  dealloc_ptr,
    output logic  dealloc_rdy,
    bitmap_if.rel bm,
    output logic  rel_done,
    output logic  rel_fire,
    output logic  rel_err,
    output ptr_t  rel_ptr
);

    rel_state_t state;

    // Pointer being released
    ptr_t       ptr_q;

    waddr_t     ptr_waddr;
    bidx_t      ptr_bit;
    word_t      bit_mask;
    // Bit still marked in use, so the free is legal
    logic       bit_set;

    assign ptr_waddr = ptr_q[PTR_WID-1:BIDX_WID];
    assign ptr_bit   = ptr_q[BIDX_WID-1:0];
    assign bit_mask  = word_t'(1) << ptr_bit;
    assign bit_set   = |(bm.rel_rd_data & bit_mask);

    // ==================================================================
    // Dealloc handshake
    // ==================================================================

    // Open only once the bitmap is cleared
    assign dealloc_rdy = (state == IDLE) && init_done;

    // ==================================================================
    // Read-modify-write
    // ==================================================================

    // Read the word in READ, data back in WRITE
    assign bm.rel_rd_en   = (state == READ);
    assign bm.rel_rd_addr = ptr_waddr;

    // Write back with the bit cleared, skipped on a double free
    assign bm.rel_wr_en   = (state == WRITE) && bit_set;
    assign bm.rel_wr_addr = ptr_waddr;
    assign bm.rel_wr_data = bm.rel_rd_data & ~bit_mask;

    // Status towards scan and control
    assign rel_fire = (state == WRITE);
    assign rel_err  = rel_fire && !bit_set;
    assign rel_done = bm.rel_wr_en;
    assign rel_ptr  = ptr_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (dealloc_req && dealloc_rdy) begin
                        state <= READ;
                    end
                end
                READ: begin
                    state <= WRITE;
                end
                WRITE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Latch the pointer on accept
    always_ff @(posedge clk) begin
        if (dealloc_req && dealloc_rdy) begin
            ptr_q <= dealloc_ptr;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module ptr_alloc_tb -f sources.f -o ptr_alloc_sim || exit 1
out=$(./obj_dir/ptr_alloc_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Test OK' && exit 0 || exit 1

/* sources.f */
hdl/alloc_pkg.sv
hdl/bitmap_if.sv
hdl/alloc_bitmap.sv
hdl/free_scan.sv
hdl/ptr_release.sv
hdl/alloc_ctrl.sv
hdl/ptr_alloc_top.sv
bench/ptr_alloc_tb.sv
